// ==== ex_pkg.sv ====
// --------------------------------------------------
// Widths, operation codes and branch conditions
// Instruction word union with its format views
// --------------------------------------------------
package ex_pkg;

    // Data path and tag widths
    localparam int XLEN  = 32;
    localparam int TAG_W = 5;

    // ALU function codes
    // MUL is steered to the Booth multiplier
    typedef enum logic [3:0] {
        ALU_ADD  = 4'h0,
        ALU_SUB  = 4'h1,
        ALU_SLT  = 4'h2,
        ALU_SLTU = 4'h3,
        ALU_AND  = 4'h4,
        ALU_OR   = 4'h5,
        ALU_XOR  = 4'h6,
        ALU_SLL  = 4'h7,
        ALU_SRL  = 4'h8,
        ALU_SRA  = 4'h9,
        ALU_MUL  = 4'ha
    } alu_func_e;

    // Operand A sources
    typedef enum logic [1:0] {
        OPA_RS1  = 2'd0,
        OPA_PC   = 2'd1,
        OPA_NPC  = 2'd2,
        OPA_ZERO = 2'd3
    } opa_sel_e;

    // Operand B sources
    typedef enum logic [2:0] {
        OPB_RS2   = 3'd0,
        OPB_I_IMM = 3'd1,
        OPB_S_IMM = 3'd2,
        OPB_B_IMM = 3'd3,
        OPB_U_IMM = 3'd4,
        OPB_J_IMM = 3'd5
    } opb_sel_e;

    // Conditional branch funct3 codes
    localparam logic [2:0] BR_EQ  = 3'b000;
    localparam logic [2:0] BR_NE  = 3'b001;
    localparam logic [2:0] BR_LT  = 3'b100;
    localparam logic [2:0] BR_GE  = 3'b101;
    localparam logic [2:0] BR_LTU = 3'b110;
    localparam logic [2:0] BR_GEU = 3'b111;

    // --------------------------------------------------
    // Instruction word, one view per RV32 format
    // --------------------------------------------------
    typedef union packed {
        struct packed {
            logic [6:0] funct7; logic [4:0] rs2; logic [4:0] rs1;
            logic [2:0] funct3; logic [4:0] rd;  logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm; logic [4:0] rs1; logic [2:0] funct3;
            logic [4:0] rd;   logic [6:0] opcode;
        } i;
        struct packed {
            logic [6:0] imm_hi; logic [4:0] rs2; logic [4:0] rs1;
            logic [2:0] funct3; logic [4:0] imm_lo; logic [6:0] opcode;
        } s;
        struct packed {
            logic       imm12;  logic [5:0] imm10_5; logic [4:0] rs2; logic [4:0] rs1;
            logic [2:0] funct3; logic [3:0] imm4_1;  logic imm11; logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm; logic [4:0] rd; logic [6:0] opcode;
        } u;
        struct packed {
            logic imm20; logic [9:0] imm10_1; logic imm11; logic [7:0] imm19_12;
            logic [4:0] rd; logic [6:0] opcode;
        } j;
    } inst_u;

endpackage

// ==== ex_alu.sv ====
// --------------------------------------------------
// Single-cycle integer ALU
// Add, sub, logic, set-less-than and shifts
// --------------------------------------------------
`timescale 1ns/1ps

module ex_alu
    import ex_pkg::*;
#(
    parameter int XLEN_P = XLEN
) (
    input  logic [XLEN_P-1:0] opa,
    input  logic [XLEN_P-1:0] opb,
    input  alu_func_e         func,
    output logic [XLEN_P-1:0] result
);

    // Shift amount width follows the data width
    localparam int SHAMT_W = $clog2(XLEN_P);

    logic signed [XLEN_P-1:0] opa_s;
    logic signed [XLEN_P-1:0] opb_s;
    logic [SHAMT_W-1:0]       shamt;

    assign opa_s = opa;
    assign opb_s = opb;
    // Low bits of B only
    assign shamt = opb[SHAMT_W-1:0];

    always_comb begin
        case (func)
            ALU_ADD:  result = opa + opb;
            ALU_SUB:  result = opa - opb;
            ALU_SLT:  result = XLEN_P'(opa_s < opb_s);
            ALU_SLTU: result = XLEN_P'(opa < opb);
            ALU_AND:  result = opa & opb;
            ALU_OR:   result = opa | opb;
            ALU_XOR:  result = opa ^ opb;
            ALU_SLL:  result = opa << shamt;
            ALU_SRL:  result = opa >> shamt;
            // Arithmetic shift keeps the sign
            ALU_SRA:  result = opa_s >>> shamt;
            // MUL and unused codes
            default:  result = '0;
        endcase
    end

endmodule

// ==== ex_branch_cond.sv ====
// --------------------------------------------------
// Conditional branch compare on rs1 and rs2
// --------------------------------------------------
`timescale 1ns/1ps

module ex_branch_cond
    import ex_pkg::*;
#(
    parameter int XLEN_P = XLEN
) (
    input  logic [2:0]        funct3,
    input  logic [XLEN_P-1:0] rs1,
    input  logic [XLEN_P-1:0] rs2,
    output logic              take
);

    // Signed copies for BLT and BGE
    logic signed [XLEN_P-1:0] rs1_s;
    logic signed [XLEN_P-1:0] rs2_s;

    assign rs1_s = rs1;
    assign rs2_s = rs2;

    always_comb begin
        case (funct3)
            BR_EQ:   take = (rs1 == rs2);
            BR_NE:   take = (rs1 != rs2);
            BR_LT:   take = (rs1_s < rs2_s);
            BR_GE:   take = (rs1_s >= rs2_s);
            BR_LTU:  take = (rs1 < rs2);
            BR_GEU:  take = (rs1 >= rs2);
            // Reserved encodings
            default: take = 1'b0;
        endcase
    end

endmodule

// ==== ex_booth_mult.sv ====
// --------------------------------------------------
// Iterative radix-2 Booth multiplier datapath
// One add or subtract and shift per step
// --------------------------------------------------
`timescale 1ns/1ps

module ex_booth_mult
    import ex_pkg::*;
#(
    parameter int XLEN_P = XLEN
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              load,
    input  logic              step,
    input  logic [XLEN_P-1:0] mcand,
    input  logic [XLEN_P-1:0] mplier,
    output logic              last,
    output logic [XLEN_P-1:0] product
);

    localparam int CNT_W = $clog2(XLEN_P);

    // Upper partial product and multiplicand
    logic [XLEN_P-1:0]  acc_q;
    logic [XLEN_P-1:0]  mcand_q;
    logic [XLEN_P-1:0]  acc_sum;
    // Product bits enter the multiplier register at the top
    logic [XLEN_P-1:0]  mplier_q;
    // Booth bit to the right of the multiplier LSB
    logic               booth_q;
    logic [CNT_W-1:0]   cnt_q;

    // Booth recoding of the two low bits
    always_comb begin
        case ({mplier_q[0], booth_q})
            2'b01:   acc_sum = acc_q + mcand_q;
            2'b10:   acc_sum = acc_q - mcand_q;
            default: acc_sum = acc_q;
        endcase
    end

    // --------------------------------------------------
    // Datapath registers
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (load) begin
            acc_q    <= '0;
            mcand_q  <= mcand;
            mplier_q <= mplier;
            booth_q  <= 1'b0;
        end else if (step) begin
            // Arithmetic shift of {acc, mplier, booth}
            acc_q    <= {acc_sum[XLEN_P-1], acc_sum[XLEN_P-1:1]};
            mplier_q <= {acc_sum[0], mplier_q[XLEN_P-1:1]};
            booth_q  <= mplier_q[0];
        end
    end

    // Step index
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt_q <= '0;
        end else if (load) begin
            cnt_q <= '0;
        end else if (step) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign last    = (cnt_q == CNT_W'(XLEN_P - 1));
    // Low half has fully shifted into the multiplier register
    assign product = mplier_q;

endmodule

// ==== ex_mul_ctrl.sv ====
// --------------------------------------------------
// Multiply sequencer FSM: IDLE, RUN, DONE
// --------------------------------------------------
`timescale 1ns/1ps

module ex_mul_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic last,
    output logic load,
    output logic step,
    output logic mul_busy,
    output logic mul_done
);

    // State encoding
    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_RUN  = 2'd1;
    localparam logic [1:0] S_DONE = 2'd2;

    logic [1:0] state_q;
    logic [1:0] state_d;

    // Next state
    always_comb begin
        case (state_q)
            S_IDLE:  state_d = start ? S_RUN : S_IDLE;
            // Final step executes on the edge that leaves RUN
            S_RUN:   state_d = last ? S_DONE : S_RUN;
            S_DONE:  state_d = S_IDLE;
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Operand capture on the accepting edge
    assign load     = (state_q == S_IDLE) && start;
    assign step     = (state_q == S_RUN);
    // Busy through DONE so issue stays held until the result is out
    assign mul_busy = (state_q != S_IDLE);
    assign mul_done = (state_q == S_DONE);

endmodule

// ==== ex_credit_counter.sv ====
// --------------------------------------------------
// Downstream credit counter, saturating at CREDITS
// --------------------------------------------------
`timescale 1ns/1ps

module ex_credit_counter #(
    parameter int CREDITS = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic spend,
    input  logic credit_return,
    output logic has_credit
);

    localparam int CNT_W = $clog2(CREDITS + 1);
    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(CREDITS);

    logic [CNT_W-1:0] cnt_q;

    // Spend and return in one edge cancel out
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt_q <= CNT_MAX;
        end else if (spend && !credit_return) begin
            cnt_q <= cnt_q - 1'b1;
        end else if (credit_return && !spend && (cnt_q != CNT_MAX)) begin
            // Extra returns at full count are dropped
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign has_credit = (cnt_q != '0);

endmodule

// ==== ex_stage.sv ====
// --------------------------------------------------
// Execute stage top: operand muxes, immediate decode
// ALU, branch compare, Booth multiplier, result port
// --------------------------------------------------
`timescale 1ns/1ps

module ex_stage
    import ex_pkg::*;
#(
    parameter int CREDITS = 4,
    parameter int XLEN_P  = XLEN
) (
    input  logic              clk,
    input  logic              rst,
    // Issue side
    input  logic              in_valid,
    input  logic [TAG_W-1:0]  in_tag,
    input  alu_func_e         in_func,
    input  opa_sel_e          in_opa_sel,
    input  opb_sel_e          in_opb_sel,
    input  logic [XLEN_P-1:0] in_rs1,
    input  logic [XLEN_P-1:0] in_rs2,
    input  logic [XLEN_P-1:0] in_pc,
    input  inst_u             in_inst,
    input  logic              in_cond_branch,
    input  logic              in_uncond_branch,
    output logic              in_ready,
    // Completion side
    input  logic              credit_return,
    output logic              out_valid,
    output logic [TAG_W-1:0]  out_tag,
    output logic [XLEN_P-1:0] out_result,
    output logic              out_take_branch
);

    logic              accept;
    logic              is_mul;
    logic              has_credit;
    logic              mul_start;
    logic              mul_load;
    logic              mul_step;
    logic              mul_last;
    logic              mul_busy;
    logic              mul_done;
    logic [XLEN_P-1:0] mul_product;
    logic [TAG_W-1:0]  mul_tag_q;
    logic [XLEN_P-1:0] npc;
    logic [XLEN_P-1:0] imm_i;
    logic [XLEN_P-1:0] imm_s;
    logic [XLEN_P-1:0] imm_b;
    logic [XLEN_P-1:0] imm_u;
    logic [XLEN_P-1:0] imm_j;
    logic [XLEN_P-1:0] opa;
    logic [XLEN_P-1:0] opb;
    logic [XLEN_P-1:0] alu_result;
    logic              cond_take;

    // Handshake
    assign in_ready  = !mul_busy && has_credit;
    assign accept    = in_valid && in_ready;
    assign is_mul    = (in_func == ALU_MUL);
    assign mul_start = accept && is_mul;
    assign npc       = in_pc + XLEN_P'(4);

    // --------------------------------------------------
    // Immediate decode, sign-extended from each view
    // --------------------------------------------------
    assign imm_i = XLEN_P'($signed(in_inst.i.imm));
    assign imm_s = XLEN_P'($signed({in_inst.s.imm_hi, in_inst.s.imm_lo}));
    assign imm_b = XLEN_P'($signed({in_inst.b.imm12, in_inst.b.imm11,
                                    in_inst.b.imm10_5, in_inst.b.imm4_1, 1'b0}));
    // U immediate fills the upper 20 bits
    assign imm_u = XLEN_P'($signed({in_inst.u.imm, 12'b0}));
    assign imm_j = XLEN_P'($signed({in_inst.j.imm20, in_inst.j.imm19_12,
                                    in_inst.j.imm11, in_inst.j.imm10_1, 1'b0}));

    // Operand A
    always_comb begin
        case (in_opa_sel)
            OPA_RS1: opa = in_rs1;
            OPA_PC:  opa = in_pc;
            OPA_NPC: opa = npc;
            default: opa = '0;
        endcase
    end

    // Operand B
    always_comb begin
        case (in_opb_sel)
            OPB_RS2:   opb = in_rs2;
            OPB_I_IMM: opb = imm_i;
            OPB_S_IMM: opb = imm_s;
            OPB_B_IMM: opb = imm_b;
            OPB_U_IMM: opb = imm_u;
            OPB_J_IMM: opb = imm_j;
            default:   opb = '0;
        endcase
    end

    // --------------------------------------------------
    // Functional units
    // --------------------------------------------------
    ex_alu #(.XLEN_P(XLEN_P)) u_alu (
        .opa    (opa),
        .opb    (opb),
        .func   (in_func),
        .result (alu_result)
    );

    // Compare always on the register values
    ex_branch_cond #(.XLEN_P(XLEN_P)) u_branch_cond (
        .funct3 (in_inst.b.funct3),
        .rs1    (in_rs1),
        .rs2    (in_rs2),
        .take   (cond_take)
    );

    ex_booth_mult #(.XLEN_P(XLEN_P)) u_booth_mult (
        .clk     (clk),
        .rst     (rst),
        .load    (mul_load),
        .step    (mul_step),
        .mcand   (opa),
        .mplier  (opb),
        .last    (mul_last),
        .product (mul_product)
    );

    ex_mul_ctrl u_mul_ctrl (
        .clk      (clk),
        .rst      (rst),
        .start    (mul_start),
        .last     (mul_last),
        .load     (mul_load),
        .step     (mul_step),
        .mul_busy (mul_busy),
        .mul_done (mul_done)
    );

    ex_credit_counter #(.CREDITS(CREDITS)) u_credit_counter (
        .clk           (clk),
        .rst           (rst),
        .spend         (accept),
        .credit_return (credit_return),
        .has_credit    (has_credit)
    );

    // --------------------------------------------------
    // Result port
    // --------------------------------------------------
    // Tag of the multiply in flight
    always_ff @(posedge clk) begin
        if (mul_start) begin
            mul_tag_q <= in_tag;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= (accept && !is_mul) || mul_done;
        end
    end

    // ALU accept and mul_done never coincide, issue is held in DONE
    always_ff @(posedge clk) begin
        if (accept && !is_mul) begin
            out_tag         <= in_tag;
            out_result      <= alu_result;
            out_take_branch <= in_uncond_branch || (in_cond_branch && cond_take);
        end else if (mul_done) begin
            out_tag         <= mul_tag_q;
            out_result      <= mul_product;
            out_take_branch <= 1'b0;
        end
    end

endmodule

// ==== tb_ex_stage.sv ====
// --------------------------------------------------
// Self-checking testbench for the execute stage
// File-driven issue, random credit return, in-order checks
// --------------------------------------------------
`timescale 1ns/1ps

module tb_ex_stage
    import ex_pkg::*;
();

    localparam int          CREDITS         = 4;
    localparam int          CLK_PERIOD      = 8;
    localparam int          MAX_TESTS       = 64;
    localparam int          CYCLES_PER_TEST = 60;
    localparam int          TAIL_NS         = 400;
    localparam string       TEST_FILE       = "ex_stage_tests.txt";
    localparam logic [31:0] SEED            = 32'ha7801093;

    logic             clk;
    logic             rst;
    logic             in_valid;
    logic [TAG_W-1:0] in_tag;
    alu_func_e        in_func;
    opa_sel_e         in_opa_sel;
    opb_sel_e         in_opb_sel;
    logic [XLEN-1:0]  in_rs1;
    logic [XLEN-1:0]  in_rs2;
    logic [XLEN-1:0]  in_pc;
    inst_u            in_inst;
    logic             in_cond_branch;
    logic             in_uncond_branch;
    logic             in_ready;
    logic             credit_return;
    logic             out_valid;
    logic [TAG_W-1:0] out_tag;
    logic [XLEN-1:0]  out_result;
    logic             out_take_branch;

    // One entry per file column
    logic [31:0] t_tag    [MAX_TESTS];
    logic [31:0] t_func   [MAX_TESTS];
    logic [31:0] t_opa    [MAX_TESTS];
    logic [31:0] t_opb    [MAX_TESTS];
    logic [31:0] t_rs1    [MAX_TESTS];
    logic [31:0] t_rs2    [MAX_TESTS];
    logic [31:0] t_pc     [MAX_TESTS];
    logic [31:0] t_inst   [MAX_TESTS];
    logic [31:0] t_cond   [MAX_TESTS];
    logic [31:0] t_uncond [MAX_TESTS];
    logic [31:0] t_res    [MAX_TESTS];
    logic [31:0] t_take   [MAX_TESTS];

    // Expected results in issue order
    logic [31:0] exp_tag_q  [$];
    logic [31:0] exp_res_q  [$];
    logic [31:0] exp_take_q [$];

    int          num_tests   = 0;
    // Accepted but credit not yet back
    int          outstanding = 0;
    // Results seen whose credit is still to be returned
    int          pending_ret = 0;
    bit          loaded      = 1'b0;
    logic [31:0] lfsr        = SEED;

    ex_stage #(.CREDITS(CREDITS), .XLEN_P(XLEN)) dut (
        .clk              (clk),
        .rst              (rst),
        .in_valid         (in_valid),
        .in_tag           (in_tag),
        .in_func          (in_func),
        .in_opa_sel       (in_opa_sel),
        .in_opb_sel       (in_opb_sel),
        .in_rs1           (in_rs1),
        .in_rs2           (in_rs2),
        .in_pc            (in_pc),
        .in_inst          (in_inst),
        .in_cond_branch   (in_cond_branch),
        .in_uncond_branch (in_uncond_branch),
        .in_ready         (in_ready),
        .credit_return    (credit_return),
        .out_valid        (out_valid),
        .out_tag          (out_tag),
        .out_result       (out_result),
        .out_take_branch  (out_take_branch)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Right-shifting Galois LFSR
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s got %h expected %h",
                     $time, what, actual, expected);
            $display("Testbench failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic fail_run(input string why);
        $display("ERROR at %0t ns: %s", $time, why);
        $display("Testbench failed");
        $fatal(1, "run stopped");
    endtask

    // Lines starting with # are skipped
    task automatic load_tests();
        int    fd;
        int    n;
        string line;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) fail_run("cannot open the tests file");
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line[0] == "#") continue;
            if (num_tests == MAX_TESTS) fail_run("too many lines in the tests file");
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                        t_tag[num_tests], t_func[num_tests], t_opa[num_tests],
                        t_opb[num_tests], t_rs1[num_tests], t_rs2[num_tests],
                        t_pc[num_tests], t_inst[num_tests], t_cond[num_tests],
                        t_uncond[num_tests], t_res[num_tests], t_take[num_tests]);
            if (n == 12) begin
                num_tests++;
            end else if (n > 0) begin
                fail_run("malformed line in the tests file");
            end
        end
        $fclose(fd);
        if (num_tests == 0) fail_run("no operations found in the tests file");
    endtask

    // Entered 1 ns after a rising edge
    // Returns 1 ns after the accepting edge
    task automatic issue(input int i);
        in_valid         = 1'b1;
        in_tag           = t_tag[i][TAG_W-1:0];
        in_func          = alu_func_e'(t_func[i][3:0]);
        in_opa_sel       = opa_sel_e'(t_opa[i][1:0]);
        in_opb_sel       = opb_sel_e'(t_opb[i][2:0]);
        in_rs1           = t_rs1[i];
        in_rs2           = t_rs2[i];
        in_pc            = t_pc[i];
        in_inst          = t_inst[i];
        in_cond_branch   = t_cond[i][0];
        in_uncond_branch = t_uncond[i][0];
        // in_ready comes from registers and holds from negedge to the next edge
        @(negedge clk);
        while (!in_ready) @(negedge clk);
        @(posedge clk);
        exp_tag_q.push_back(t_tag[i]);
        exp_res_q.push_back(t_res[i]);
        exp_take_q.push_back(t_take[i]);
        #1;
        in_valid = 1'b0;
    endtask

    // --------------------------------------------------
    // Result and credit monitor
    // --------------------------------------------------
    always @(negedge clk) begin
        if (!rst) begin
            if (outstanding == CREDITS) begin
                check(32'(in_ready), 32'd0, "in_ready with every credit in use");
            end
            if (out_valid) begin
                if (exp_tag_q.size() == 0) fail_run("result with no operation outstanding");
                check(32'(out_tag), exp_tag_q.pop_front(), "out_tag");
                check(out_result, exp_res_q.pop_front(), "out_result");
                check(32'(out_take_branch), exp_take_q.pop_front(), "out_take_branch");
                pending_ret++;
            end
            // Events of the coming edge
            if (in_valid && in_ready) outstanding++;
            if (credit_return) outstanding--;
        end
    end

    // Completion side frees slots at random
    always @(posedge clk) begin
        #1;
        credit_return = 1'b0;
        if (!rst && pending_ret > 0) begin
            if (lfsr[0]) begin
                credit_return = 1'b1;
                pending_ret--;
            end
            lfsr = lfsr_step(lfsr);
        end
    end

    // Watchdog sized from the number of operations
    initial begin
        wait (loaded);
        #(num_tests * CYCLES_PER_TEST * CLK_PERIOD + TAIL_NS);
        fail_run("timeout, results or credits did not drain in time");
    end

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        rst              = 1'b1;
        in_valid         = 1'b0;
        in_tag           = '0;
        in_func          = ALU_ADD;
        in_opa_sel       = OPA_RS1;
        in_opb_sel       = OPB_RS2;
        in_rs1           = '0;
        in_rs2           = '0;
        in_pc            = '0;
        in_inst          = '0;
        in_cond_branch   = 1'b0;
        in_uncond_branch = 1'b0;
        credit_return    = 1'b0;
        load_tests();
        loaded = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        // Idle state before any issue
        @(negedge clk);
        check(32'(out_valid), 32'd0, "out_valid after reset");
        check(32'(in_ready), 32'd1, "in_ready after reset");
        @(posedge clk);
        #1;
        for (int i = 0; i < num_tests; i++) begin
            issue(i);
        end
        while (exp_tag_q.size() != 0) @(negedge clk);
        while (outstanding != 0) @(negedge clk);
        check(32'(in_ready), 32'd1, "in_ready with all credits back");
        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== ex_stage.f ====
ex_pkg.sv
ex_alu.sv
ex_branch_cond.sv
ex_booth_mult.sv
ex_mul_ctrl.sv
ex_credit_counter.sv
ex_stage.sv
tb_ex_stage.sv

// ==== Makefile ====
# Verilator lint, simulation and clean for the execute stage

VERILATOR ?= verilator
TOP       := tb_ex_stage
FILELIST  := ex_stage.f
VFLAGS    := --binary --timing -j 0
LINTFLAGS := --lint-only --timing
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Testbench passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== ex_stage_tests.txt ====
# tag func opa_sel opb_sel rs1 rs2 pc inst cond uncond exp_result exp_take (all hex)
# func 0 ADD 1 SUB 2 SLT 3 SLTU 4 AND 5 OR 6 XOR 7 SLL 8 SRL 9 SRA a MUL
01 0 0 0 00000005 00000003 00000000 00000033 0 0 00000008 0
02 1 0 0 00000003 00000005 00000000 40000033 0 0 fffffffe 0
03 2 0 0 ffffffff 00000001 00000000 00002033 0 0 00000001 0
04 3 0 0 ffffffff 00000001 00000000 00003033 0 0 00000000 0
05 4 0 0 f0f0f0f0 ff00ff00 00000000 00007033 0 0 f000f000 0
06 5 0 0 f0f0f0f0 0f0f0000 00000000 00006033 0 0 fffff0f0 0
07 6 0 0 aaaaaaaa ffffffff 00000000 00004033 0 0 55555555 0
08 7 0 0 00000001 0000003f 00000000 00001033 0 0 80000000 0
09 8 0 0 80000000 00000024 00000000 00005033 0 0 08000000 0
0a 9 0 0 80000000 00000024 00000000 40005033 0 0 f8000000 0
0b 0 0 1 00000100 00000000 00000000 fff00013 0 0 000000ff 0
0c 0 3 2 00000000 00000000 00000000 fe000c23 0 0 fffffff8 0
0d 0 1 3 00000000 00000000 00001000 fe0008e3 0 0 00000ff0 0
0e 0 3 4 00000000 00000000 00000000 12345037 0 0 12345000 0
0f 0 1 4 00000000 00000000 00002000 fffff017 0 0 00001000 0
10 0 1 5 00000000 00000000 00003000 0010006f 0 1 00003800 1
11 0 1 5 00000000 00000000 00003000 ffdff06f 0 1 00002ffc 1
12 0 2 0 00000000 00000000 00004000 0000006f 0 1 00004004 1
13 0 1 3 00000005 00000005 00001000 fe0008e3 1 0 00000ff0 1
14 0 1 3 00000005 00000005 00001000 fe0018e3 1 0 00000ff0 0
15 0 1 3 ffffffff 00000001 00001000 fe0048e3 1 0 00000ff0 1
16 0 1 3 ffffffff 00000001 00001000 fe0058e3 1 0 00000ff0 0
17 0 1 3 ffffffff 00000001 00001000 fe0068e3 1 0 00000ff0 0
18 0 1 3 ffffffff 00000001 00001000 fe0078e3 1 0 00000ff0 1
19 a 0 0 00000007 00000006 00000000 02000033 0 0 0000002a 0
1a a 0 0 fffffffd 00000005 00000000 02000033 0 0 fffffff1 0
1b a 0 0 fffffffc fffffffc 00000000 02000033 0 0 00000010 0
1c a 0 0 80000000 ffffffff 00000000 02000033 0 0 80000000 0
1d a 0 0 00001234 ffffff00 00000000 02000033 0 0 ffedcc00 0
1e 0 0 0 00000001 00000001 00000000 00000033 0 0 00000002 0
